//--- Bender.yml
package:
  name: lsu_lite

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_split_fsm.sv
      - source/lsu_outstanding_cnt.sv
      - source/lsu_req_format.sv
      - source/lsu_rdata_align.sv
      - source/lsu_lite.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_lsu_mem.sv
      - test/tb_lsu_lite.sv

//--- lsu_lite.f
+incdir+source
source/lsu_pkg.sv
source/lsu_split_fsm.sv
source/lsu_outstanding_cnt.sv
source/lsu_req_format.sv
source/lsu_rdata_align.sv
source/lsu_lite.sv
test/tb_lsu_mem.sv
test/tb_lsu_lite.sv

//--- source/lsu_lite.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_lite (
  input  wire logic           clk,
  input  wire logic           rst_n,
  // Command
  input  wire logic           cmd_valid_i,
  output logic                cmd_ready_o,
  input  wire logic           cmd_we_i,
  input  wire lsu_pkg::size_t cmd_size_i,
  input  wire logic           cmd_sext_i,
  input  wire lsu_pkg::addr_t cmd_base_i,
  input  wire lsu_pkg::addr_t cmd_offset_i,
  input  wire lsu_pkg::data_t cmd_wdata_i,
  // Memory bus
  output logic                data_req_o,
  input  wire logic           data_gnt_i,
  output lsu_pkg::addr_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::data_t      data_wdata_o,
  input  wire logic           data_rvalid_i,
  input  wire lsu_pkg::data_t data_rdata_i,
  // Result
  output logic                result_valid_o,
  output lsu_pkg::data_t      result_rdata_o,
  output logic                busy_o
);

  logic split;          // Command needs two phases
  logic issue_ok;       // Counter lets a phase go out
  logic accept;         // Phase granted
  logic second_phase;
  logic last_phase;

  assign data_we_o = cmd_we_i;   // Same direction for both halves

  lsu_split_fsm u_split_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid_i),
    .split_i        (split),
    .issue_ok_i     (issue_ok),
    .data_gnt_i     (data_gnt_i),
    .data_req_o     (data_req_o),
    .accept_o       (accept),
    .second_phase_o (second_phase),
    .last_phase_o   (last_phase),
    .cmd_ready_o    (cmd_ready_o)
  );

  lsu_outstanding_cnt u_cnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept_i   (accept),
    .rvalid_i   (data_rvalid_i),
    .req_i      (data_req_o),
    .issue_ok_o (issue_ok),
    .busy_o     (busy_o)
  );

  lsu_req_format u_req_fmt (
    .cmd_base_i     (cmd_base_i),
    .cmd_offset_i   (cmd_offset_i),
    .cmd_size_i     (cmd_size_i),
    .cmd_wdata_i    (cmd_wdata_i),
    .second_phase_i (second_phase),
    .split_o        (split),
    .data_addr_o    (data_addr_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o)
  );

  // Read side follows each grant
  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .last_phase_i   (last_phase),
    .cmd_we_i       (cmd_we_i),
    .cmd_size_i     (cmd_size_i),
    .cmd_sext_i     (cmd_sext_i),
    .offset_i       (data_addr_o[1:0]),
    .rvalid_i       (data_rvalid_i),
    .rdata_i        (data_rdata_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o)
  );

endmodule

`default_nettype wire

//--- source/lsu_outstanding_cnt.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_outstanding_cnt (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic accept_i,   // Phase granted
  input  wire logic rvalid_i,   // Response for the oldest phase
  input  wire logic req_i,      // Request on the bus right now
  output logic      issue_ok_o,
  output logic      busy_o
);

  lsu_pkg::cnt_t cnt_q;
  lsu_pkg::cnt_t cnt_d;
  logic          count_up;

  // Never count past the depth
  assign count_up = accept_i && (cnt_q < lsu_pkg::cnt_t'(`LSU_DEPTH));

  always_comb begin
    cnt_d = cnt_q;
    if (count_up && !rvalid_i) begin
      cnt_d = cnt_q + lsu_pkg::cnt_t'(1);
    end else if (!count_up && rvalid_i) begin
      cnt_d = cnt_q - lsu_pkg::cnt_t'(1);
    end                                       // Up and down together cancel out
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Issue when idle, or in lock step with the response before it,
  // so the read side sees one access at a time
  assign issue_ok_o = (cnt_q < lsu_pkg::cnt_t'(`LSU_DEPTH)) &&
                      ((cnt_q == '0) || rvalid_i);

  assign busy_o = (cnt_q != '0) || req_i;   // Anything in flight or asked for

endmodule

`default_nettype wire

//--- source/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////
// Outstanding transactions
////////////////////

`define LSU_DEPTH 2        // Max granted but unanswered phases
`define LSU_CNT_W 2        // Wide enough to hold 0..LSU_DEPTH

////////////////////
// Access size codes
////////////////////

`define LSU_SIZE_BYTE 2'd0
`define LSU_SIZE_HALF 2'd1
`define LSU_SIZE_WORD 2'd2

`endif

//--- source/lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  // Vector types that carry a meaning
  typedef logic [31:0]           addr_t;    // Byte address
  typedef logic [31:0]           data_t;    // Bus or register word
  typedef logic [3:0]            be_t;      // One enable per byte lane
  typedef logic [1:0]            size_t;    // Byte, half or word code
  typedef logic [1:0]            offset_t;  // Byte offset inside a word
  typedef logic [`LSU_CNT_W-1:0] cnt_t;     // Outstanding count

  // Split-access sequencer state
  typedef enum logic {
    PHASE_FIRST,   // Aligned access, or first half of a split one
    PHASE_SECOND   // Second half, goes to the next word
  } phase_e;

endpackage

`default_nettype wire

//--- source/lsu_rdata_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_rdata_align (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             accept_i,      // Phase granted
  input  wire logic             last_phase_i,  // Granted phase ends its command
  input  wire logic             cmd_we_i,
  input  wire lsu_pkg::size_t   cmd_size_i,
  input  wire logic             cmd_sext_i,
  input  wire lsu_pkg::offset_t offset_i,      // Low bits of the bus address
  input  wire logic             rvalid_i,
  input  wire lsu_pkg::data_t   rdata_i,
  output logic                  result_valid_o,
  output lsu_pkg::data_t        result_rdata_o
);

  lsu_pkg::size_t   size_q;
  logic             sext_q;
  logic             we_q;
  lsu_pkg::offset_t offset_q;
  logic             last_q;
  lsu_pkg::data_t   rdata_q;       // First half of a split load

  logic             is_split;
  logic [63:0]      merged;
  lsu_pkg::data_t   aligned;       // Addressed bytes moved down to lane 0

  ////////////////////
  // Access attributes
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q   <= `LSU_SIZE_BYTE;
      sext_q   <= 1'b0;
      we_q     <= 1'b0;
      offset_q <= '0;
      last_q   <= 1'b1;              // Next grant starts a command
    end else if (accept_i) begin
      size_q <= cmd_size_i;
      sext_q <= cmd_sext_i;
      we_q   <= cmd_we_i;
      if (last_q) begin
        offset_q <= offset_i;        // Second half keeps the offset of the first
      end
      last_q <= last_phase_i;
    end
  end

  // Hold the low part until the second response arrives
  always_ff @(posedge clk) begin
    if (rvalid_i && !last_q && !we_q) begin
      rdata_q <= rdata_i;
    end
  end

  ////////////////////
  // Realign and extend
  ////////////////////

  assign is_split = ((size_q == `LSU_SIZE_WORD) && (offset_q != 2'b00)) ||
                    ((size_q == `LSU_SIZE_HALF) && (offset_q == 2'b11));

  // Split loads take their low bytes from the stored half
  assign merged  = is_split ? {rdata_i, rdata_q} : {rdata_i, rdata_i};
  assign aligned = lsu_pkg::data_t'(merged >> {offset_q, 3'b000});

  always_comb begin
    case (size_q)
      `LSU_SIZE_BYTE: result_rdata_o = {{24{sext_q && aligned[7]}}, aligned[7:0]};
      `LSU_SIZE_HALF: result_rdata_o = {{16{sext_q && aligned[15]}}, aligned[15:0]};
      default:        result_rdata_o = aligned;
    endcase
  end

  assign result_valid_o = rvalid_i && last_q;   // One result per command

endmodule

`default_nettype wire

//--- source/lsu_req_format.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_req_format (
  input  wire lsu_pkg::addr_t cmd_base_i,
  input  wire lsu_pkg::addr_t cmd_offset_i,
  input  wire lsu_pkg::size_t cmd_size_i,
  input  wire lsu_pkg::data_t cmd_wdata_i,
  input  wire logic           second_phase_i,  // Build the second half of a split
  output logic                split_o,
  output lsu_pkg::addr_t      data_addr_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::data_t      data_wdata_o
);

  lsu_pkg::addr_t   addr;
  lsu_pkg::offset_t offset;
  lsu_pkg::addr_t   next_word;

  ////////////////////
  // Address
  ////////////////////

  assign addr      = cmd_base_i + cmd_offset_i;
  assign offset    = addr[1:0];
  assign next_word = {addr[31:2], 2'b00} + 32'd4;   // Target of the second half

  assign data_addr_o = second_phase_i ? next_word : addr;

  // Word off a boundary, or a halfword crossing into the next word
  assign split_o = ((cmd_size_i == `LSU_SIZE_WORD) && (offset != 2'b00)) ||
                   ((cmd_size_i == `LSU_SIZE_HALF) && (offset == 2'b11));

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    data_be_o = 4'b0000;
    case (cmd_size_i)
      `LSU_SIZE_BYTE: begin
        data_be_o = 4'b0001 << offset;          // One lane
      end
      `LSU_SIZE_HALF: begin
        if (second_phase_i) begin
          data_be_o = 4'b0001;                  // Upper byte spills to lane 0
        end else begin
          case (offset)
            2'b00:   data_be_o = 4'b0011;
            2'b01:   data_be_o = 4'b0110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;       // Lower byte only
          endcase
        end
      end
      default: begin                            // Word
        if (second_phase_i) begin
          case (offset)
            2'b01:   data_be_o = 4'b0001;
            2'b10:   data_be_o = 4'b0011;
            2'b11:   data_be_o = 4'b0111;
            default: data_be_o = 4'b0000;       // Aligned word has no second half
          endcase
        end else begin
          case (offset)
            2'b00:   data_be_o = 4'b1111;
            2'b01:   data_be_o = 4'b1110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end
      end
    endcase
  end

  ////////////////////
  // Store data
  ////////////////////

  // Rotate left by the offset, same lanes serve both halves
  always_comb begin
    case (offset)
      2'b00:   data_wdata_o = cmd_wdata_i;
      2'b01:   data_wdata_o = {cmd_wdata_i[23:0], cmd_wdata_i[31:24]};
      2'b10:   data_wdata_o = {cmd_wdata_i[15:0], cmd_wdata_i[31:16]};
      default: data_wdata_o = {cmd_wdata_i[7:0],  cmd_wdata_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

//--- source/lsu_split_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_split_fsm (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic cmd_valid_i,     // Command waiting in the LSU
  input  wire logic split_i,         // Command needs two bus phases
  input  wire logic issue_ok_i,      // Counter allows a new phase
  input  wire logic data_gnt_i,
  output logic      data_req_o,
  output logic      accept_o,        // Phase granted this cycle
  output logic      second_phase_o,  // Formatter builds the second half
  output logic      last_phase_o,    // Current phase ends the command
  output logic      cmd_ready_o
);

  lsu_pkg::phase_e phase_q;
  lsu_pkg::phase_e phase_d;

  ////////////////////
  // Bus request
  ////////////////////

  assign data_req_o = cmd_valid_i && issue_ok_i;
  assign accept_o   = data_req_o && data_gnt_i;    // req/gnt handshake

  assign second_phase_o = (phase_q == lsu_pkg::PHASE_SECOND);

  // Only the first half of a split access is not the last one
  assign last_phase_o = !(split_i && (phase_q == lsu_pkg::PHASE_FIRST));

  // Command leaves the LSU with the grant of its last phase
  assign cmd_ready_o = accept_o && last_phase_o;

  ////////////////////
  // Phase sequencing
  ////////////////////

  always_comb begin
    phase_d = phase_q;
    if (!cmd_valid_i) begin
      phase_d = lsu_pkg::PHASE_FIRST;        // Next command always starts fresh
    end else if (accept_o) begin
      if (last_phase_o) begin
        phase_d = lsu_pkg::PHASE_FIRST;      // Done, back for the next command
      end else begin
        phase_d = lsu_pkg::PHASE_SECOND;     // First half out, issue the rest
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= lsu_pkg::PHASE_FIRST;
    end else begin
      phase_q <= phase_d;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_lsu_lite.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_lite;

  localparam int N_OPS = 25;

  logic clk, rst_n, cmd_valid, cmd_ready, cmd_we, cmd_sext;
  lsu_pkg::size_t cmd_size;
  lsu_pkg::addr_t cmd_base, cmd_offset, data_addr;
  lsu_pkg::data_t cmd_wdata, data_wdata, data_rdata, result_rdata;
  lsu_pkg::be_t   data_be;
  logic data_req, data_gnt, data_we, data_rvalid, result_valid, busy;

  // Op table
  logic           t_we [N_OPS];
  lsu_pkg::size_t t_size [N_OPS];
  logic           t_sext [N_OPS];
  lsu_pkg::addr_t t_base [N_OPS], t_off [N_OPS], t_addr [N_OPS];
  lsu_pkg::data_t t_wdata [N_OPS], t_rdata [N_OPS];
  lsu_pkg::be_t   t_be [N_OPS];
  logic           t_split [N_OPS];
  int             op_count;

  int cur, phase_no, outstanding, results, idx;
  int pend_q[$];                         // Ops waiting for their result
  logic held;                            // Request seen stalled last cycle
  lsu_pkg::addr_t held_addr, exp_addr;
  lsu_pkg::be_t   held_be, exp_be;
  lsu_pkg::data_t held_wdata;
  logic [63:0]    rot;

  lsu_lite dut0 (
    .clk(clk), .rst_n(rst_n), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
    .cmd_we_i(cmd_we), .cmd_size_i(cmd_size), .cmd_sext_i(cmd_sext),
    .cmd_base_i(cmd_base), .cmd_offset_i(cmd_offset), .cmd_wdata_i(cmd_wdata),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_addr_o(data_addr),
    .data_we_o(data_we), .data_be_o(data_be), .data_wdata_o(data_wdata),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata),
    .result_valid_o(result_valid), .result_rdata_o(result_rdata), .busy_o(busy)
  );

  tb_lsu_mem mem0 (
    .clk(clk), .rst_n(rst_n), .req_i(data_req), .addr_i(data_addr), .we_i(data_we),
    .be_i(data_be), .wdata_i(data_wdata), .gnt_o(data_gnt), .rvalid_o(data_rvalid),
    .rdata_o(data_rdata)
  );

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic add_op(input logic we, input lsu_pkg::size_t size, input logic sext,
                        input lsu_pkg::addr_t base, input lsu_pkg::addr_t off,
                        input lsu_pkg::data_t wdata, input lsu_pkg::addr_t addr,
                        input lsu_pkg::be_t be, input logic split,
                        input lsu_pkg::data_t rdata);
    t_we[op_count]    = we;
    t_size[op_count]  = size;
    t_sext[op_count]  = sext;
    t_base[op_count]  = base;
    t_off[op_count]   = off;
    t_wdata[op_count] = wdata;
    t_addr[op_count]  = addr;
    t_be[op_count]    = be;
    t_split[op_count] = split;
    t_rdata[op_count] = rdata;
    op_count = op_count + 1;
  endtask

  // Lanes that spill past the word boundary
  function automatic lsu_pkg::be_t spill_be(input lsu_pkg::size_t size,
                                            input logic [1:0] off);
    int n;
    n = (size == `LSU_SIZE_WORD) ? 4 : 2;
    return lsu_pkg::be_t'((1 << (off + n - 4)) - 1);
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((N_OPS * 20 + 16) * 10);
    $display("Timeout: the op table did not finish in time");
    stop_run();
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (data_rvalid) begin
        if (outstanding == 0) begin
          $display("Response arrived at %0t with nothing outstanding", $time);
          stop_run();
        end
        outstanding = outstanding - 1;
      end
      if (result_valid) begin
        if (pend_q.size() == 0) begin
          $display("Result at %0t with no command pending", $time);
          stop_run();
        end
        idx = pend_q.pop_front();          // Results come in command order
        if (!t_we[idx]) check_value("result_rdata_o", result_rdata, t_rdata[idx]);
        results = results + 1;
      end
      if (held && data_req) begin          // Stalled request must not move
        check_value("data_addr_o", data_addr, held_addr);
        check_value("data_be_o", 32'(data_be), 32'(held_be));
        check_value("data_wdata_o", data_wdata, held_wdata);
      end
      held       = data_req && !data_gnt;
      held_addr  = data_addr;
      held_be    = data_be;
      held_wdata = data_wdata;
      if (data_req && data_gnt) begin
        outstanding = outstanding + 1;
        if (outstanding > 2) begin
          $display("More than two phases outstanding at %0t", $time);
          stop_run();
        end
        if (phase_no == 0) begin
          exp_addr = t_addr[cur];
          exp_be   = t_be[cur];
        end else begin
          exp_addr = (t_addr[cur] | 32'h3) + 32'd1;   // Byte after this word's last one
          exp_be   = spill_be(t_size[cur], t_addr[cur][1:0]);
        end
        check_value("data_addr_o", data_addr, exp_addr);
        check_value("data_be_o", 32'(data_be), 32'(exp_be));
        check_value("data_we_o", 32'(data_we), 32'(t_we[cur]));
        if (t_we[cur]) begin
          rot = {t_wdata[cur], t_wdata[cur]} >> (32 - 8 * t_addr[cur][1:0]);
          check_value("data_wdata_o", data_wdata, rot[31:0]);
        end
        phase_no = phase_no + 1;
        check_value("cmd_ready_o", 32'(cmd_ready), 32'(phase_no == t_split[cur] + 1));
        if (cmd_ready) pend_q.push_back(cur);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_we      = 1'b0;
    cmd_sext    = 1'b0;
    cmd_size    = '0;
    cmd_base    = '0;
    cmd_offset  = '0;
    cmd_wdata   = '0;
    op_count    = 0;
    cur         = 0;
    phase_no    = 0;
    outstanding = 0;
    results     = 0;
    held        = 1'b0;
    // Stores, aligned then split
    add_op(1, `LSU_SIZE_WORD, 0, 32'h10, 0,  32'hA1B2C3D4, 32'h10, 4'b1111, 0, 0);
    add_op(1, `LSU_SIZE_HALF, 0, 32'h14, 2,  32'h0000BEEF, 32'h16, 4'b1100, 0, 0);
    add_op(1, `LSU_SIZE_BYTE, 0, 32'h18, 1,  32'h0000005A, 32'h19, 4'b0010, 0, 0);
    add_op(1, `LSU_SIZE_WORD, 0, 32'h20, 1,  32'h11223344, 32'h21, 4'b1110, 1, 0);
    add_op(1, `LSU_SIZE_WORD, 0, 32'h30, 2,  32'h55667788, 32'h32, 4'b1100, 1, 0);
    add_op(1, `LSU_SIZE_WORD, 0, 32'h38, 11, 32'h99AABBCC, 32'h43, 4'b1000, 1, 0);
    add_op(1, `LSU_SIZE_HALF, 0, 32'h50, 3,  32'h0000F00D, 32'h53, 4'b1000, 1, 0);
    // Loads back over the stored bytes
    add_op(0, `LSU_SIZE_WORD, 0, 32'h10, 0, 0, 32'h10, 4'b1111, 0, 32'hA1B2C3D4);
    add_op(0, `LSU_SIZE_HALF, 0, 32'h14, 2, 0, 32'h16, 4'b1100, 0, 32'h0000BEEF);
    add_op(0, `LSU_SIZE_HALF, 1, 32'h14, 2, 0, 32'h16, 4'b1100, 0, 32'hFFFFBEEF);
    add_op(0, `LSU_SIZE_BYTE, 1, 32'h18, 1, 0, 32'h19, 4'b0010, 0, 32'h0000005A);
    add_op(0, `LSU_SIZE_BYTE, 1, 32'h10, 3, 0, 32'h13, 4'b1000, 0, 32'hFFFFFFA1);
    add_op(0, `LSU_SIZE_BYTE, 0, 32'h10, 3, 0, 32'h13, 4'b1000, 0, 32'h000000A1);
    add_op(0, `LSU_SIZE_WORD, 0, 32'h20, 1, 0, 32'h21, 4'b1110, 1, 32'h11223344);
    add_op(0, `LSU_SIZE_WORD, 0, 32'h30, 2, 0, 32'h32, 4'b1100, 1, 32'h55667788);
    add_op(0, `LSU_SIZE_WORD, 0, 32'h40, 3, 0, 32'h43, 4'b1000, 1, 32'h99AABBCC);
    add_op(0, `LSU_SIZE_HALF, 1, 32'h50, 3, 0, 32'h53, 4'b1000, 1, 32'hFFFFF00D);
    add_op(0, `LSU_SIZE_HALF, 0, 32'h50, 3, 0, 32'h53, 4'b1000, 1, 32'h0000F00D);
    // Loads of untouched memory
    add_op(0, `LSU_SIZE_WORD, 0, 32'h80, 1, 0, 32'h81, 4'b1110, 1, 32'h84838281);
    add_op(0, `LSU_SIZE_HALF, 1, 32'h88, 2, 0, 32'h8A, 4'b1100, 0, 32'hFFFF8B8A);
    add_op(0, `LSU_SIZE_HALF, 0, 32'h60, 1, 0, 32'h61, 4'b0110, 0, 32'h00006261);
    add_op(0, `LSU_SIZE_BYTE, 1, 32'h9C, 2, 0, 32'h9E, 4'b0100, 0, 32'hFFFFFF9E);
    // Overlapping stores merged in memory
    add_op(0, `LSU_SIZE_WORD, 0, 32'h10, 2, 0, 32'h12, 4'b1100, 1, 32'h1514A1B2);
    add_op(1, `LSU_SIZE_BYTE, 0, 32'h20, 2, 32'h000000E7, 32'h22, 4'b0100, 0, 0);
    add_op(0, `LSU_SIZE_WORD, 0, 32'h20, 0, 0, 32'h20, 4'b1111, 0, 32'h22E74420);

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("busy_o", 32'(busy), 0);
    check_value("data_req_o", 32'(data_req), 0);

    for (int i = 0; i < N_OPS; i++) begin
      @(negedge clk);
      cur        = i;
      phase_no   = 0;
      cmd_valid  = 1'b1;
      cmd_we     = t_we[i];
      cmd_size   = t_size[i];
      cmd_sext   = t_sext[i];
      cmd_base   = t_base[i];
      cmd_offset = t_off[i];
      cmd_wdata  = t_wdata[i];
      do @(posedge clk); while (!cmd_ready);   // Held until the last phase goes
    end
    @(negedge clk);
    cmd_valid = 1'b0;

    while (results < N_OPS) @(posedge clk);
    @(negedge clk);
    check_value("busy_o", 32'(busy), 0);
    check_value("data_req_o", 32'(data_req), 0);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mem (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           req_i,
  input  wire lsu_pkg::addr_t addr_i,
  input  wire logic           we_i,
  input  wire lsu_pkg::be_t   be_i,
  input  wire lsu_pkg::data_t wdata_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output lsu_pkg::data_t      rdata_o
);

  logic [7:0]     mem [0:255];    // Byte array, low address bits only
  lsu_pkg::data_t rdata_fifo[$];  // Responses in grant order
  int             due_fifo[$];    // Cycle in which each response may go out
  int             cycle;
  int             last_due;
  int             stall_left;     // Grant-low cycles still to come
  int             due;
  integer         seed;
  logic [7:0]     word_base;

  initial begin
    seed = 53;
    for (int a = 0; a < 256; a++) begin
      mem[a] = a[7:0];              // Each byte holds its own address
    end
    gnt_o      = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    cycle      = 0;
    last_due   = 0;
    stall_left = 0;
  end

  ////////////////////
  // Grant side
  ////////////////////

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst_n && req_i && gnt_o) begin
      word_base = {addr_i[7:2], 2'b00};
      rdata_fifo.push_back({mem[word_base + 3], mem[word_base + 2],
                            mem[word_base + 1], mem[word_base]});
      if (we_i) begin
        for (int k = 0; k < 4; k++) begin
          if (be_i[k]) mem[word_base + k] = wdata_i[8*k +: 8];  // Byte lanes
        end
      end
      due = cycle + ({$random(seed)} % 3);    // Latency 1 to 3 cycles
      if (due <= last_due) due = last_due + 1; // Keep responses in order
      last_due = due;
      due_fifo.push_back(due);
      stall_left = {$random(seed)} % 3;        // Stall the next grant 0 to 2
    end
  end

  // Bus outputs change on the falling edge only
  always @(negedge clk) begin
    rvalid_o = 1'b0;
    if ((due_fifo.size() > 0) && (due_fifo[0] <= cycle)) begin
      rvalid_o = 1'b1;
      rdata_o  = rdata_fifo.pop_front();
      void'(due_fifo.pop_front());
    end
    if (stall_left > 0) begin
      gnt_o      = 1'b0;
      stall_left = stall_left - 1;
    end else begin
      gnt_o = rst_n;
    end
  end

endmodule

`default_nettype wire
